/* hdl/frontend_consts.svh */
//////////////////////////////
// frontend constants
// widths, buffer depth, opcodes and class codes
//////////////////////////////

`ifndef FRONTEND_CONSTS_SVH
`define FRONTEND_CONSTS_SVH

// pipeline widths
`define FETCH_WIDTH    4
`define DISPATCH_WIDTH 2

// buffer depth, power of two so pointers wrap by truncation
`define IB_DEPTH       8

`define RESET_PC       32'h0000_0000

// rv32 major opcodes
`define OPC_OP         7'b0110011
`define OPC_OP_IMM     7'b0010011
`define OPC_LUI        7'b0110111
`define OPC_AUIPC      7'b0010111
`define OPC_LOAD       7'b0000011
`define OPC_STORE      7'b0100011
`define OPC_BRANCH     7'b1100011
`define OPC_JAL        7'b1101111
`define OPC_JALR       7'b1100111

// instruction classes
`define CLASS_ALU      3'd0
`define CLASS_LOAD     3'd1
`define CLASS_STORE    3'd2
`define CLASS_BRANCH   3'd3
`define CLASS_ILLEGAL  3'd4

`endif

/* hdl/frontend_pkg.sv */
//////////////////////////////
// frontend package
// shared vector types and packet structs
//////////////////////////////

`default_nettype none

`include "frontend_consts.svh"

package frontend_pkg;

    //////////////////////////////
    // plain vector types
    //////////////////////////////

    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  arch_reg_t;
    typedef logic [2:0]  op_class_t;

    // counts sized to hold 0..max inclusive
    typedef logic [$clog2(`FETCH_WIDTH+1)-1:0]    fetch_count_t;
    typedef logic [$clog2(`DISPATCH_WIDTH+1)-1:0] disp_count_t;
    typedef logic [$clog2(`IB_DEPTH+1)-1:0]       ib_count_t;

    //////////////////////////////
    // packets
    //////////////////////////////

    // raw word stamped with its pc
    typedef struct packed {
        inst_t inst;
        addr_t pc;
        logic  valid;
    } inst_packet_t;

    // decoded form handed to rename
    typedef struct packed {
        inst_t     inst;
        addr_t     pc;
        op_class_t op_class;
        arch_reg_t rd;
        arch_reg_t rs1;
        arch_reg_t rs2;
        logic      writes_rd;
        logic      valid;
    } decoded_packet_t;

endpackage

`default_nettype wire

/* hdl/fetch_stage.sv */
//////////////////////////////
// fetch stage
// pc register, accept clamp, pc stamping
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "frontend_consts.svh"

module fetch_stage (
    input  logic                                         clock,
    input  logic                                         reset,
    input  frontend_pkg::inst_t        [`FETCH_WIDTH-1:0] fetch_insts,
    input  frontend_pkg::fetch_count_t                    fetch_count,
    input  frontend_pkg::ib_count_t                       ib_open,
    output frontend_pkg::addr_t                           pc,
    output frontend_pkg::fetch_count_t                    fetch_accepted,
    output frontend_pkg::inst_packet_t [`FETCH_WIDTH-1:0] new_packets
);

    // take whatever fits in the buffer
    // fetch_count <= 4 so the narrowed ib_open fits when it is smaller
    always_comb begin
        if (frontend_pkg::ib_count_t'(fetch_count) <= ib_open) begin
            fetch_accepted = fetch_count;
        end else begin
            fetch_accepted = frontend_pkg::fetch_count_t'(ib_open);
        end
    end

    // slot i gets pc + 4*i
    // valid only for the accepted prefix
    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            new_packets[i].inst  = fetch_insts[i];
            new_packets[i].pc    = pc + frontend_pkg::addr_t'(4 * i);
            new_packets[i].valid = (i < fetch_accepted);
        end
    end

    // sequential only, no redirect path
    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= `RESET_PC;
        end else begin
            pc <= pc + (frontend_pkg::addr_t'(fetch_accepted) << 2);
        end
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    // never hand the buffer more than it reported free
    accept_fits_buffer: assert property (
        @(posedge clock) disable iff (reset)
        frontend_pkg::ib_count_t'(fetch_accepted) <= ib_open
    ) else $error("fetch accepted %0d words with only %0d open", fetch_accepted, ib_open);

endmodule

`default_nettype wire

/* hdl/inst_buffer.sv */
//////////////////////////////
// instruction buffer
// circular queue, multi push and multi pop
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "frontend_consts.svh"

module inst_buffer (
    input  logic                                             clock,
    input  logic                                             reset,
    input  frontend_pkg::inst_packet_t [`FETCH_WIDTH-1:0]    new_packets,
    input  frontend_pkg::fetch_count_t                       push_count,
    input  frontend_pkg::disp_count_t                        pop_count,
    output frontend_pkg::inst_packet_t [`DISPATCH_WIDTH-1:0] head_packets,
    output frontend_pkg::ib_count_t                          ib_open
);

    localparam int PTR_W = $clog2(`IB_DEPTH);

    typedef logic [PTR_W-1:0] ib_ptr_t;

    //////////////////////////////
    // storage and pointers
    //////////////////////////////

    frontend_pkg::inst_packet_t entries [`IB_DEPTH];

    // head = oldest, tail = next free
    ib_ptr_t head;
    ib_ptr_t tail;

    // held entries, 0..IB_DEPTH
    frontend_pkg::ib_count_t count;

    // per-slot indices, wrap by truncation
    ib_ptr_t [`FETCH_WIDTH-1:0]    wr_idx;
    ib_ptr_t [`DISPATCH_WIDTH-1:0] rd_idx;

    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            wr_idx[i] = tail + ib_ptr_t'(i);
        end
        for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
            rd_idx[i] = head + ib_ptr_t'(i);
        end
    end

    //////////////////////////////
    // outputs
    //////////////////////////////

    // room from registered count
    // pops this cycle show up next cycle
    assign ib_open = frontend_pkg::ib_count_t'(`IB_DEPTH) - count;

    // oldest entries, valid only where actually held
    always_comb begin
        for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
            head_packets[i]       = entries[rd_idx[i]];
            head_packets[i].valid = (i < count);
        end
    end

    //////////////////////////////
    // update
    //////////////////////////////

    // payload writes at the tail
    always_ff @(posedge clock) begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            if (i < push_count) begin
                entries[wr_idx[i]] <= new_packets[i];
            end
        end
    end

    // pointer and count bookkeeping
    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= head + ib_ptr_t'(pop_count);
            tail  <= tail + ib_ptr_t'(push_count);
            count <= count
                   + frontend_pkg::ib_count_t'(push_count)
                   - frontend_pkg::ib_count_t'(pop_count);
        end
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    // dispatch may only retire what is held
    pop_within_held: assert property (
        @(posedge clock) disable iff (reset)
        frontend_pkg::ib_count_t'(pop_count) <= count
    ) else $error("buffer pop %0d with %0d held", pop_count, count);

    // fetch must respect the open count
    push_within_room: assert property (
        @(posedge clock) disable iff (reset)
        frontend_pkg::ib_count_t'(push_count) <= ib_open
    ) else $error("buffer push %0d with %0d open", push_count, ib_open);

endmodule

`default_nettype wire

/* hdl/dispatch_stage.sv */
//////////////////////////////
// dispatch stage
// picks count, decodes, registers packets
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "frontend_consts.svh"

module dispatch_stage (
    input  logic                                                clock,
    input  logic                                                reset,
    input  frontend_pkg::inst_packet_t    [`DISPATCH_WIDTH-1:0] head_packets,
    input  frontend_pkg::disp_count_t                           rob_open,
    output frontend_pkg::disp_count_t                           dispatch_num,
    output frontend_pkg::decoded_packet_t [`DISPATCH_WIDTH-1:0] dispatched,
    output frontend_pkg::disp_count_t                           dispatch_count
);

    // opcode -> class, field extraction
    function automatic frontend_pkg::decoded_packet_t decode_inst(
        input frontend_pkg::inst_packet_t pkt
    );
        frontend_pkg::decoded_packet_t d;
        logic [6:0] opcode;
        logic       has_dest;
        opcode     = pkt.inst[6:0];
        d.inst     = pkt.inst;
        d.pc       = pkt.pc;
        d.rd       = pkt.inst[11:7];
        d.rs1      = pkt.inst[19:15];
        d.rs2      = pkt.inst[24:20];
        d.valid    = pkt.valid;
        case (opcode)
            `OPC_OP, `OPC_OP_IMM, `OPC_LUI, `OPC_AUIPC: d.op_class = `CLASS_ALU;
            `OPC_LOAD:                                  d.op_class = `CLASS_LOAD;
            `OPC_STORE:                                 d.op_class = `CLASS_STORE;
            `OPC_BRANCH, `OPC_JAL, `OPC_JALR:           d.op_class = `CLASS_BRANCH;
            default:                                    d.op_class = `CLASS_ILLEGAL;
        endcase
        // jumps link into rd, plain branches do not
        has_dest = (d.op_class == `CLASS_ALU) || (d.op_class == `CLASS_LOAD)
                || (opcode == `OPC_JAL) || (opcode == `OPC_JALR);
        // x0 writes are dropped
        d.writes_rd = has_dest && (d.rd != '0);
        return d;
    endfunction

    //////////////////////////////
    // dispatch count
    //////////////////////////////

    frontend_pkg::disp_count_t held;
    frontend_pkg::disp_count_t limit;

    // min(held, width, rob_open)
    always_comb begin
        held = '0;
        for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
            held = held + frontend_pkg::disp_count_t'(head_packets[i].valid);
        end
        if (rob_open > frontend_pkg::disp_count_t'(`DISPATCH_WIDTH)) begin
            limit = frontend_pkg::disp_count_t'(`DISPATCH_WIDTH);
        end else begin
            limit = rob_open;
        end
        dispatch_num = (held < limit) ? held : limit;
    end

    //////////////////////////////
    // decode and register
    //////////////////////////////

    frontend_pkg::decoded_packet_t [`DISPATCH_WIDTH-1:0] decoded;

    always_comb begin
        for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
            decoded[i]       = decode_inst(head_packets[i]);
            // slots past the count stay invalid
            decoded[i].valid = (i < dispatch_num);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            dispatch_count <= '0;
            for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
                dispatched[i].valid <= 1'b0;
            end
        end else begin
            dispatch_count <= dispatch_num;
            dispatched     <= decoded;
        end
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    logic [`DISPATCH_WIDTH-1:0] valid_vec;
    logic [`DISPATCH_WIDTH-1:0] expected_vec;

    always_comb begin
        for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
            valid_vec[i]    = dispatched[i].valid;
            expected_vec[i] = (i < dispatch_count);
        end
    end

    // valid prefix from slot 0, length matches dispatch_count
    valid_contiguous: assert property (
        @(posedge clock) disable iff (reset)
        valid_vec == expected_vec
    ) else $error("dispatch valid bits %b, count %0d", valid_vec, dispatch_count);

endmodule

`default_nettype wire

/* hdl/frontend.sv */
//////////////////////////////
// frontend top
// fetch -> instruction buffer -> dispatch
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "frontend_consts.svh"

module frontend (
    input  logic                                                clock,
    input  logic                                                reset,
    input  frontend_pkg::inst_t           [`FETCH_WIDTH-1:0]    fetch_insts,
    input  frontend_pkg::fetch_count_t                          fetch_count,
    input  frontend_pkg::disp_count_t                           rob_open,
    output frontend_pkg::addr_t                                 pc,
    output frontend_pkg::ib_count_t                             ib_open,
    output frontend_pkg::fetch_count_t                          fetch_accepted,
    output frontend_pkg::decoded_packet_t [`DISPATCH_WIDTH-1:0] dispatched,
    output frontend_pkg::disp_count_t                           dispatch_count
);

    //////////////////////////////
    // internal wires
    //////////////////////////////

    // stamped words, fetch to buffer
    frontend_pkg::inst_packet_t [`FETCH_WIDTH-1:0]    new_packets;

    // oldest entries, buffer to dispatch
    frontend_pkg::inst_packet_t [`DISPATCH_WIDTH-1:0] head_packets;

    // pop count back to the buffer
    frontend_pkg::disp_count_t                        dispatch_num;

    // fetch: pc and accept clamp
    fetch_stage fetch_stage_i (
        .clock          (clock),
        .reset          (reset),
        .fetch_insts    (fetch_insts),
        .fetch_count    (fetch_count),
        .ib_open        (ib_open),
        .pc             (pc),
        .fetch_accepted (fetch_accepted),
        .new_packets    (new_packets)
    );

    // buffer: push what fetch took, pop what dispatch took
    inst_buffer inst_buffer_i (
        .clock        (clock),
        .reset        (reset),
        .new_packets  (new_packets),
        .push_count   (fetch_accepted),
        .pop_count    (dispatch_num),
        .head_packets (head_packets),
        .ib_open      (ib_open)
    );

    // dispatch: rob-limited, registered decode
    dispatch_stage dispatch_stage_i (
        .clock          (clock),
        .reset          (reset),
        .head_packets   (head_packets),
        .rob_open       (rob_open),
        .dispatch_num   (dispatch_num),
        .dispatched     (dispatched),
        .dispatch_count (dispatch_count)
    );

endmodule

`default_nettype wire

/* testbench/frontend_tb.sv */
//////////////////////////////
// frontend testbench
// table-driven stimulus against a queue model
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "frontend_consts.svh"

module frontend_tb;

    // one table row = one cycle of inputs
    typedef struct packed {
        frontend_pkg::inst_t [`FETCH_WIDTH-1:0] words;
        frontend_pkg::fetch_count_t             count;
        frontend_pkg::disp_count_t              rob;
    } row_t;

    logic clock;
    logic reset;
    frontend_pkg::inst_t           [`FETCH_WIDTH-1:0]    fetch_insts;
    frontend_pkg::fetch_count_t                          fetch_count;
    frontend_pkg::disp_count_t                           rob_open;
    frontend_pkg::addr_t                                 pc;
    frontend_pkg::ib_count_t                             ib_open;
    frontend_pkg::fetch_count_t                          fetch_accepted;
    frontend_pkg::decoded_packet_t [`DISPATCH_WIDTH-1:0] dispatched;
    frontend_pkg::disp_count_t                           dispatch_count;

    frontend uut (
        .clock          (clock),
        .reset          (reset),
        .fetch_insts    (fetch_insts),
        .fetch_count    (fetch_count),
        .rob_open       (rob_open),
        .pc             (pc),
        .ib_open        (ib_open),
        .fetch_accepted (fetch_accepted),
        .dispatched     (dispatched),
        .dispatch_count (dispatch_count)
    );

    //////////////////////////////
    // table, model state, counters
    //////////////////////////////

    row_t  rows[$];
    string names[$];
    bit    table_ready;
    int    seed;

    // reference: held entries, pc, registered outputs
    frontend_pkg::inst_packet_t    model_q[$];
    frontend_pkg::addr_t           model_pc;
    frontend_pkg::decoded_packet_t exp_disp [`DISPATCH_WIDTH];
    int                            exp_dcount;
    int                            total_in;
    int                            total_out;

    string cur_test;
    int    test_checks;
    int    test_errors;
    int    num_tests;
    int    checks;
    int    errors;

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // rd/rs fields around an opcode
    function automatic frontend_pkg::inst_t make_word(
        input logic [6:0] opc, input int rd, input int rs1, input int rs2
    );
        return {7'b0, 5'(rs2), 5'(rs1), 3'b000, 5'(rd), opc};
    endfunction

    function automatic frontend_pkg::decoded_packet_t expected_decode(
        input frontend_pkg::inst_packet_t p
    );
        frontend_pkg::decoded_packet_t e;
        logic links;
        e.inst  = p.inst;
        e.pc    = p.pc;
        e.rd    = p.inst[11:7];
        e.rs1   = p.inst[19:15];
        e.rs2   = p.inst[24:20];
        e.valid = 1'b1;
        links   = 1'b0;
        case (p.inst[6:0])
            `OPC_OP, `OPC_OP_IMM, `OPC_LUI, `OPC_AUIPC: begin
                e.op_class = `CLASS_ALU;
                links      = 1'b1;
            end
            `OPC_LOAD: begin
                e.op_class = `CLASS_LOAD;
                links      = 1'b1;
            end
            `OPC_STORE:  e.op_class = `CLASS_STORE;
            `OPC_BRANCH: e.op_class = `CLASS_BRANCH;
            // jumps write the link register
            `OPC_JAL, `OPC_JALR: begin
                e.op_class = `CLASS_BRANCH;
                links      = 1'b1;
            end
            default: e.op_class = `CLASS_ILLEGAL;
        endcase
        e.writes_rd = links && (e.rd != 5'd0);
        return e;
    endfunction

    task automatic add_row(input string name, input frontend_pkg::inst_t w0,
                           input frontend_pkg::inst_t w1, input frontend_pkg::inst_t w2,
                           input frontend_pkg::inst_t w3, input int count, input int rob);
        row_t r;
        r.words = {w3, w2, w1, w0};
        r.count = 3'(count);
        r.rob   = 2'(rob);
        rows.push_back(r);
        names.push_back(name);
    endtask

    task automatic build_table();
        logic [31:0] r;
        logic [31:0] w [`FETCH_WIDTH];
        // every opcode group, rd zero and an illegal opcode
        add_row("decode", make_word(`OPC_OP, 1, 2, 3), make_word(`OPC_OP_IMM, 0, 4, 5),
                make_word(`OPC_LUI, 5, 6, 7), make_word(`OPC_AUIPC, 6, 8, 9), 4, 2);
        add_row("decode", make_word(`OPC_LOAD, 7, 10, 11), make_word(`OPC_STORE, 8, 12, 13),
                make_word(`OPC_BRANCH, 9, 14, 15), make_word(`OPC_JAL, 1, 16, 17), 4, 2);
        add_row("decode", make_word(`OPC_JALR, 0, 18, 19), make_word(7'b1111111, 10, 20, 21),
                make_word(`OPC_LOAD, 0, 22, 23), make_word(`OPC_OP, 31, 30, 29), 2, 2);
        // mixed counts and rob limits
        add_row("in_order", make_word(`OPC_OP, 3, 1, 1), 32'h0, 32'h0, 32'h0, 1, 1);
        add_row("in_order", make_word(`OPC_OP, 4, 2, 2), make_word(`OPC_LOAD, 5, 3, 3),
                make_word(`OPC_STORE, 6, 4, 4), 32'h0, 3, 3);
        add_row("in_order", 32'h0, 32'h0, 32'h0, 32'h0, 0, 1);
        add_row("in_order", make_word(`OPC_BRANCH, 2, 5, 6), make_word(`OPC_OP, 7, 8, 9),
                32'h0, 32'h0, 2, 2);
        // rob stalls, buffer fills, pc holds
        repeat (5) begin
            add_row("backpressure", make_word(`OPC_OP_IMM, 11, 12, 13),
                    make_word(`OPC_LUI, 14, 15, 16), make_word(`OPC_OP, 17, 18, 19),
                    make_word(`OPC_LOAD, 20, 21, 22), 4, 0);
        end
        repeat (3) add_row("resume", make_word(`OPC_OP, 23, 24, 25), 32'h0, 32'h0, 32'h0, 1, 2);
        // long stream, pointers wrap several times
        repeat (60) begin
            for (int k = 0; k < `FETCH_WIDTH; k++) begin
                r = $random(seed);
                case (r[3:0])
                    4'd0: w[k] = {r[31:7], `OPC_OP};
                    4'd1: w[k] = {r[31:7], `OPC_OP_IMM};
                    4'd2: w[k] = {r[31:7], `OPC_LUI};
                    4'd3: w[k] = {r[31:7], `OPC_LOAD};
                    4'd4: w[k] = {r[31:7], `OPC_STORE};
                    4'd5: w[k] = {r[31:7], `OPC_BRANCH};
                    4'd6: w[k] = {r[31:7], `OPC_JAL};
                    4'd7: w[k] = {r[31:7], `OPC_JALR};
                    default: w[k] = r;
                endcase
            end
            r = $random(seed);
            add_row("random", w[0], w[1], w[2], w[3], int'(r[7:0] % 5), int'(r[9:8]));
        end
        repeat (6) add_row("drain", 32'h0, 32'h0, 32'h0, 32'h0, 0, 2);
        add_row("drain", 32'h0, 32'h0, 32'h0, 32'h0, 0, 0);
    endtask

    //////////////////////////////
    // checking
    //////////////////////////////

    task automatic check_field(input string field, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        test_checks++;
        assert (actual === expected) else begin
            $display("** Error %s %s: expected %0h, actual %0h",
                     cur_test, field, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_outputs();
        for (int k = 0; k < `DISPATCH_WIDTH; k++) begin
            check_field($sformatf("slot%0d valid", k), 32'(exp_disp[k].valid),
                        32'(dispatched[k].valid));
            if (exp_disp[k].valid) begin
                check_field($sformatf("slot%0d pc", k), exp_disp[k].pc, dispatched[k].pc);
                check_field($sformatf("slot%0d inst", k), exp_disp[k].inst, dispatched[k].inst);
                check_field($sformatf("slot%0d class", k), 32'(exp_disp[k].op_class),
                            32'(dispatched[k].op_class));
                check_field($sformatf("slot%0d rd", k), 32'(exp_disp[k].rd),
                            32'(dispatched[k].rd));
                check_field($sformatf("slot%0d rs1", k), 32'(exp_disp[k].rs1),
                            32'(dispatched[k].rs1));
                check_field($sformatf("slot%0d rs2", k), 32'(exp_disp[k].rs2),
                            32'(dispatched[k].rs2));
                check_field($sformatf("slot%0d writes_rd", k), 32'(exp_disp[k].writes_rd),
                            32'(dispatched[k].writes_rd));
            end
        end
        check_field("dispatch_count", 32'(exp_dcount), 32'(dispatch_count));
        total_out += int'(dispatch_count);
    endtask

    task automatic finish_test();
        $display("test %s: %0d checks, %0d errors", cur_test, test_checks, test_errors);
        num_tests++;
        test_checks = 0;
        test_errors = 0;
    endtask

    // check this cycle, then advance the model one edge
    task automatic check_and_advance(input row_t r);
        int open;
        int acc;
        int num;
        open = `IB_DEPTH - model_q.size();
        acc  = (int'(r.count) < open) ? int'(r.count) : open;
        check_field("pc", model_pc, pc);
        check_field("ib_open", 32'(open), 32'(ib_open));
        check_field("fetch_accepted", 32'(acc), 32'(fetch_accepted));
        check_outputs();
        // min of held, width, rob slots
        num = (model_q.size() < `DISPATCH_WIDTH) ? model_q.size() : `DISPATCH_WIDTH;
        if (int'(r.rob) < num) begin
            num = int'(r.rob);
        end
        for (int k = 0; k < `DISPATCH_WIDTH; k++) begin
            exp_disp[k] = '0;
            if (k < num) begin
                exp_disp[k] = expected_decode(model_q.pop_front());
            end
        end
        exp_dcount = num;
        for (int k = 0; k < acc; k++) begin
            model_q.push_back({r.words[k], model_pc + 32'(4 * k), 1'b1});
        end
        model_pc += 32'(4 * acc);
        total_in += acc;
    endtask

    //////////////////////////////
    // run
    //////////////////////////////

    initial begin : main
        reset       = 1'b1;
        fetch_insts = '0;
        fetch_count = '0;
        rob_open    = '0;
        seed        = 32'ha780;
        build_table();
        table_ready = 1'b1;
        model_pc    = `RESET_PC;
        exp_dcount  = 0;
        for (int k = 0; k < `DISPATCH_WIDTH; k++) begin
            exp_disp[k] = '0;
        end
        repeat (10) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        cur_test = "reset";
        check_field("pc", `RESET_PC, pc);
        check_field("ib_open", `IB_DEPTH, 32'(ib_open));
        check_outputs();
        for (int i = 0; i < rows.size(); i++) begin
            @(posedge clock);
            fetch_insts <= rows[i].words;
            fetch_count <= rows[i].count;
            rob_open    <= rows[i].rob;
            @(negedge clock);
            if (names[i] != cur_test) begin
                finish_test();
                cur_test = names[i];
            end
            check_and_advance(rows[i]);
        end
        // nothing lost, nothing doubled
        check_field("stream total", 32'(total_in), 32'(total_out));
        check_field("ib_open at end", `IB_DEPTH, 32'(ib_open));
        finish_test();
        $display("summary: %0d tests, %0d checks, %0d errors", num_tests, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        int limit;
        int cycles;
        wait (table_ready);
        limit  = rows.size() + 20;
        cycles = 0;
        while (cycles < limit) begin
            @(posedge clock);
            cycles++;
        end
        $display("timeout: the run went past %0d cycles without finishing", limit);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* frontend.f */
+incdir+hdl
hdl/frontend_pkg.sv
hdl/fetch_stage.sv
hdl/inst_buffer.sv
hdl/dispatch_stage.sv
hdl/frontend.sv
testbench/frontend_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the frontend testbench with verilator and run it
set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f frontend.f --top-module frontend_tb --Mdir "$build_dir" -o frontend_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/frontend_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "TESTBENCH FAILED" "$log_file"; then
    exit 1
fi
if ! grep -q "TESTBENCH PASSED" "$log_file"; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0
